//--- Makefile
VERILATOR ?= verilator
TOP       ?= fb_doubler_tb
FILELIST  ?= fb_doubler.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= All tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-f $(FILELIST) -Mdir $(OBJ_DIR)
	$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- common/fb_regs_pkg.sv
package fb_regs_pkg;

	// CPU port widths
	localparam int REG_ADDR_W = 8;
	localparam int REG_DATA_W = 16;

	// Only the low nibble of the address is decoded
	localparam int REG_DEC_W = 4;

	// Window and stride fields
	localparam int FIELD_W = 9;
	localparam int BASE_W = 16;

	// Register map
	localparam logic [REG_DEC_W-1:0] REG_CTRL   = 4'd0; // Bit 0 is fb_enable
	localparam logic [REG_DEC_W-1:0] REG_X1     = 4'd1;
	localparam logic [REG_DEC_W-1:0] REG_Y1     = 4'd2;
	localparam logic [REG_DEC_W-1:0] REG_X2     = 4'd3;
	localparam logic [REG_DEC_W-1:0] REG_Y2     = 4'd4;
	localparam logic [REG_DEC_W-1:0] REG_STRIDE = 4'd9;  // Bytes per framebuffer row
	localparam logic [REG_DEC_W-1:0] REG_BASE   = 4'd10; // Word address of row 0

	// Overlay configuration as seen by the blit engine
	typedef struct packed {
		logic               enable;
		logic [FIELD_W-1:0] x1;
		logic [FIELD_W-1:0] x2;
		logic [FIELD_W-1:0] y1;
		logic [FIELD_W-1:0] y2;
		logic [FIELD_W-1:0] stride;
		logic [BASE_W-1:0]  base;
	} fb_cfg_t;

endpackage

//--- common/fb_video_pkg.sv
package fb_video_pkg;

	// Coordinates
	localparam int COORD_W = 9;  // Framebuffer x/y and scanline entry
	localparam int DISP_W = 10;  // Display beam position

	// Pixel and colour widths
	localparam int PIX_W = 8;
	localparam int ARGB_W = 16;
	localparam int PAL_ADDR_W = 8;

	// Memory channel
	localparam int BYTE_ADDR_W = 17;
	localparam int MEM_ADDR_W = 16;
	localparam int MEM_DATA_W = 16;

	typedef logic [PIX_W-1:0]       pix_idx_t;  // Palette index
	typedef logic [ARGB_W-1:0]      argb_t;     // ARGB 4:4:4:4
	typedef logic [COORD_W-1:0]     coord_t;
	typedef logic [DISP_W-1:0]      disp_coord_t;
	typedef logic [MEM_ADDR_W-1:0]  mem_addr_t; // Word address
	typedef logic [MEM_DATA_W-1:0]  mem_data_t;

	// Bit 0 picks the byte within a word, upper bits are the word address
	typedef logic [BYTE_ADDR_W-1:0] byte_addr_t;

	// Strobes from the blit FSM to the address counter
	typedef struct packed {
		logic load_frame; // First row of the window
		logic step_x;     // Next pixel in the row
		logic next_row;   // Advance by one stride
	} blit_cmd_t;

endpackage

//--- fb_doubler.f
common/fb_regs_pkg.sv
common/fb_video_pkg.sv
hdl/dual_port_ram.sv
fb_doubler/fb_reg_file.sv
fb_doubler/blit_addr_counter.sv
fb_doubler/blit_fsm.sv
fb_doubler/scanline_pingpong.sv
fb_doubler/fb_doubler.sv
verification/fb_doubler_chk.sv
verification/fb_doubler_tb.sv

//--- fb_doubler/blit_addr_counter.sv
module blit_addr_counter
	import fb_regs_pkg::*;
	import fb_video_pkg::*;
(
	input  logic       CLK,
	input  logic       RSTb,
	input  fb_cfg_t    cfg,
	input  blit_cmd_t  cmd,
	output coord_t     x,
	output logic       x_last,
	output byte_addr_t byte_addr
);

	byte_addr_t row_addr;   // Byte address of the current row start
	byte_addr_t frame_addr;
	byte_addr_t row_next;

	// base is a word address
	assign frame_addr = {cfg.base, 1'b0};
	assign row_next = row_addr + byte_addr_t'(cfg.stride);

	// End of row compare kept here only
	assign x_last = (x == cfg.x2);

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			x <= '0;
			row_addr <= '0;
			byte_addr <= '0;
		end else if (cmd.load_frame) begin
			x <= cfg.x1;
			row_addr <= frame_addr;
			byte_addr <= frame_addr;
		end else if (cmd.next_row) begin
			x <= cfg.x1;
			row_addr <= row_next;
			byte_addr <= row_next; // Restart at left edge of next row
		end else if (cmd.step_x) begin
			x <= x + 1'b1;
			byte_addr <= byte_addr + 1'b1;
		end
	end

endmodule

//--- fb_doubler/blit_fsm.sv
module blit_fsm
	import fb_regs_pkg::*;
	import fb_video_pkg::*;
(
	input  logic        CLK,
	input  logic        RSTb,
	input  fb_cfg_t     cfg,
	input  disp_coord_t display_y,
	input  logic        H_tick,
	input  logic        x_last,
	input  byte_addr_t  byte_addr,
	output blit_cmd_t   cmd,
	output mem_addr_t   memory_address,
	input  mem_data_t   memory_data,
	output logic        rvalid,
	input  logic        rready,
	output logic        pix_wr,
	output pix_idx_t    pix_data
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_FETCH,
		S_WRITE,
		S_ROW_DONE,
		S_WAIT_PAIR
	} state_t;

	state_t         state;
	state_t         state_next;
	coord_t         q;          // Line pair index
	logic           row_start;
	logic           in_window;
	logic           last_row;
	pix_idx_t       pix_q;

	assign q = display_y[DISP_W-1:1];
	assign row_start = H_tick && !display_y[0]; // Same event as the buffer flip
	assign in_window = cfg.enable && (q >= cfg.y1) && (q < cfg.y2);
	assign last_row = ({1'b0, q} + 1'b1) >= {1'b0, cfg.y2}; // Extra bit avoids wrap
	assign memory_address = byte_addr[BYTE_ADDR_W-1:1];
	assign pix_data = pix_q;

	always_comb begin
		state_next = state;
		cmd = '0;
		rvalid = 1'b0;
		pix_wr = 1'b0;
		case (state)
			S_IDLE: begin
				if (row_start && in_window) begin
					cmd.load_frame = (q == cfg.y1); // Top of window
					state_next = S_FETCH;
				end
			end
			S_FETCH: begin
				rvalid = 1'b1; // Held until the word arrives
				if (rready) begin
					state_next = S_WRITE;
				end
			end
			S_WRITE: begin
				pix_wr = 1'b1;
				if (x_last) begin
					state_next = S_ROW_DONE;
				end else begin
					cmd.step_x = 1'b1;
					state_next = S_FETCH;
				end
			end
			S_ROW_DONE: begin
				cmd.next_row = 1'b1;
				state_next = last_row ? S_IDLE : S_WAIT_PAIR;
			end
			S_WAIT_PAIR: begin
				if (row_start) begin
					state_next = cfg.enable ? S_FETCH : S_IDLE;
				end
			end
			default: begin
				state_next = S_IDLE;
			end
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state <= S_IDLE;
		end else begin
			state <= state_next;
		end
	end

	// Odd byte address takes the high byte
	always_ff @(posedge CLK) begin
		if (state == S_FETCH && rready) begin
			pix_q <= byte_addr[0] ? memory_data[PIX_W +: PIX_W] : memory_data[0 +: PIX_W];
		end
	end

endmodule

//--- fb_doubler/fb_doubler.sv
module fb_doubler
	import fb_regs_pkg::*;
	import fb_video_pkg::*;
(
	input  logic                  CLK,
	input  logic                  RSTb,

	// CPU register and palette port
	input  logic [REG_ADDR_W-1:0] address,
	input  logic [REG_DATA_W-1:0] data_in,
	input  logic                  wr_reg,
	input  logic                  wr_pal,

	// Display side
	input  disp_coord_t           display_x,
	input  disp_coord_t           display_y,
	input  logic                  H_tick,     // One cycle at display_x 0
	output argb_t                 color,

	// Memory request channel
	output mem_addr_t             memory_address,
	input  mem_data_t             memory_data,
	output logic                  rvalid,     // Level request
	input  logic                  rready      // Data valid this cycle
);

	fb_cfg_t    cfg;
	blit_cmd_t  cmd;
	coord_t     x;
	logic       x_last;
	byte_addr_t byte_addr;
	logic       pix_wr;
	pix_idx_t   pix_data;
	pix_idx_t   idx;

	fb_reg_file i_fb_reg_file (
		.CLK     (CLK),
		.RSTb    (RSTb),
		.address (address),
		.data_in (data_in),
		.wr_reg  (wr_reg),
		.cfg     (cfg)
	);

	blit_fsm i_blit_fsm (
		.CLK            (CLK),
		.RSTb           (RSTb),
		.cfg            (cfg),
		.display_y      (display_y),
		.H_tick         (H_tick),
		.x_last         (x_last),
		.byte_addr      (byte_addr),
		.cmd            (cmd),
		.memory_address (memory_address),
		.memory_data    (memory_data),
		.rvalid         (rvalid),
		.rready         (rready),
		.pix_wr         (pix_wr),
		.pix_data       (pix_data)
	);

	blit_addr_counter i_blit_addr_counter (
		.CLK       (CLK),
		.RSTb      (RSTb),
		.cfg       (cfg),
		.cmd       (cmd),
		.x         (x),
		.x_last    (x_last),
		.byte_addr (byte_addr)
	);

	scanline_pingpong i_scanline_pingpong (
		.CLK       (CLK),
		.RSTb      (RSTb),
		.display_x (display_x),
		.display_y (display_y),
		.H_tick    (H_tick),
		.wr_x      (x),
		.pix_wr    (pix_wr),
		.pix_data  (pix_data),
		.idx       (idx)
	);

	// Palette lookup, second cycle of the readout
	dual_port_ram #(
		.payload_t (argb_t),
		.ADDR_W    (PAL_ADDR_W)
	) i_palette (
		.CLK     (CLK),
		.rd_addr (idx),
		.rd_data (color),
		.wr_addr (address),
		.wr_data (data_in),
		.wr_en   (wr_pal)
	);

endmodule

//--- fb_doubler/fb_reg_file.sv
module fb_reg_file
	import fb_regs_pkg::*;
(
	input  logic                  CLK,
	input  logic                  RSTb,
	input  logic [REG_ADDR_W-1:0] address,
	input  logic [REG_DATA_W-1:0] data_in,
	input  logic                  wr_reg,
	output fb_cfg_t               cfg
);

	logic [REG_DEC_W-1:0] reg_sel;

	assign reg_sel = address[REG_DEC_W-1:0]; // Upper bits alias

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			cfg <= '0; // Overlay off, empty window
		end else if (wr_reg) begin
			case (reg_sel)
				REG_CTRL: begin
					cfg.enable <= data_in[0];
				end
				REG_X1: begin
					cfg.x1 <= data_in[FIELD_W-1:0];
				end
				REG_Y1: begin
					cfg.y1 <= data_in[FIELD_W-1:0];
				end
				REG_X2: begin
					cfg.x2 <= data_in[FIELD_W-1:0]; // Inclusive
				end
				REG_Y2: begin
					cfg.y2 <= data_in[FIELD_W-1:0]; // Exclusive
				end
				REG_STRIDE: begin
					cfg.stride <= data_in[FIELD_W-1:0];
				end
				REG_BASE: begin
					cfg.base <= data_in[BASE_W-1:0];
				end
				default: begin
					// Unmapped, write dropped
				end
			endcase
		end
	end

endmodule

//--- fb_doubler/scanline_pingpong.sv
module scanline_pingpong
	import fb_video_pkg::*;
(
	input  logic        CLK,
	input  logic        RSTb,
	input  disp_coord_t display_x,
	input  disp_coord_t display_y,
	input  logic        H_tick,
	input  coord_t      wr_x,
	input  logic        pix_wr,
	input  pix_idx_t    pix_data,
	output pix_idx_t    idx
);

	// Write port of one scanline RAM
	typedef struct packed {
		logic     en;
		coord_t   addr;
		pix_idx_t data;
	} line_wr_t;

	logic     disp_sel;   // RAM currently on screen
	logic     read_sel;   // disp_sel aligned with the read data
	coord_t   rd_entry;
	coord_t   clr_entry;
	line_wr_t line_wr [2];
	pix_idx_t line_rd [2];

	assign rd_entry = display_x[DISP_W-1:1]; // Each entry spans two columns
	assign clr_entry = rd_entry - 1'b1;      // One behind the beam

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			disp_sel <= 1'b0;
			read_sel <= 1'b0;
		end else begin
			if (H_tick && !display_y[0]) begin
				disp_sel <= ~disp_sel; // Freshly blitted row goes on screen
			end
			read_sel <= disp_sel;
		end
	end

	always_comb begin
		for (int i = 0; i < 2; i++) begin
			if (i == int'(disp_sel)) begin
				// Clear on the second line of the pair
				line_wr[i] = '{en: display_y[0], addr: clr_entry, data: '0};
			end else begin
				line_wr[i] = '{en: pix_wr, addr: wr_x, data: pix_data};
			end
		end
	end

	for (genvar g = 0; g < 2; g++) begin : g_line
		dual_port_ram #(
			.payload_t (pix_idx_t),
			.ADDR_W    (COORD_W)
		) i_line_ram (
			.CLK     (CLK),
			.rd_addr (rd_entry),
			.rd_data (line_rd[g]),
			.wr_addr (line_wr[g].addr),
			.wr_data (line_wr[g].data),
			.wr_en   (line_wr[g].en)
		);
	end

	assign idx = line_rd[read_sel];

endmodule

//--- hdl/dual_port_ram.sv
module dual_port_ram #(
	parameter type payload_t = logic [7:0],
	parameter int  ADDR_W = 9
) (
	input  logic              CLK,
	input  logic [ADDR_W-1:0] rd_addr,
	output payload_t          rd_data,
	input  logic [ADDR_W-1:0] wr_addr,
	input  payload_t          wr_data,
	input  logic              wr_en
);

	localparam int DEPTH = 2 ** ADDR_W;

	payload_t mem [DEPTH];

	always_ff @(posedge CLK) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// Registered read, one cycle latency
	always_ff @(posedge CLK) begin
		rd_data <= mem[rd_addr];
	end

endmodule

//--- verification/fb_doubler_chk.sv
module fb_doubler_chk
	import fb_video_pkg::*;
(
	input logic      CLK,
	input logic      RSTb,
	input logic      rvalid,
	input logic      rready,
	input mem_addr_t memory_address
);

	timeunit 1ns;
	timeprecision 100ps;

	// No memory request while in reset
	assert property (@(posedge CLK) !RSTb |-> !rvalid)
		else $error("rvalid is high during reset");

	// Address held until the word arrives
	assert property (@(posedge CLK) disable iff (!RSTb)
		rvalid && !rready |=> $stable(memory_address))
		else $error("memory_address changed during a pending request");

	assert property (@(posedge CLK) disable iff (!RSTb)
		rvalid && !rready |=> rvalid)
		else $error("rvalid dropped before rready");

endmodule

bind fb_doubler fb_doubler_chk i_fb_doubler_chk (
	.CLK            (CLK),
	.RSTb           (RSTb),
	.rvalid         (rvalid),
	.rready         (rready),
	.memory_address (memory_address)
);

//--- verification/fb_doubler_tb.sv
module fb_doubler_tb
	import fb_regs_pkg::*;
	import fb_video_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int LINE_LEN = 64;  // Display columns incl. blanking
	localparam int ACTIVE_W = 48;  // Columns compared against the reference
	localparam int FRAME_H = 40;
	localparam int FRAME_CYCLES = LINE_LEN * FRAME_H;
	localparam int N_TESTS = 5;
	localparam int TIMEOUT_CYCLES = 4 * N_TESTS * FRAME_CYCLES + 1000;
	localparam logic [15:0] SEED = 16'd20;

	logic                  CLK;
	logic                  RSTb = 1'b0;
	logic [REG_ADDR_W-1:0] address = '0;
	logic [REG_DATA_W-1:0] data_in = '0;
	logic                  wr_reg = 1'b0;
	logic                  wr_pal = 1'b0;
	disp_coord_t           display_x = '0;
	disp_coord_t           display_y = '0;
	logic                  H_tick = 1'b1;
	argb_t                 color;
	mem_addr_t             memory_address;
	mem_data_t             memory_data = '0;
	logic                  rvalid;
	logic                  rready = 1'b0;

	disp_coord_t shown_x = '0; // Beam position that color belongs to
	disp_coord_t shown_y = '0;
	fb_cfg_t     win = '0;     // Window as last written
	logic [7:0]  fb_mem [2 ** 17];
	argb_t       pal_model [256];
	logic [15:0] lfsr = SEED;
	int          wait_left = 0;
	int          cycles = 0;
	int          checks = 0;
	int          errors = 0;

	fb_doubler i_fb_doubler (
		.CLK            (CLK),
		.RSTb           (RSTb),
		.address        (address),
		.data_in        (data_in),
		.wr_reg         (wr_reg),
		.wr_pal         (wr_pal),
		.display_x      (display_x),
		.display_y      (display_y),
		.H_tick         (H_tick),
		.color          (color),
		.memory_address (memory_address),
		.memory_data    (memory_data),
		.rvalid         (rvalid),
		.rready         (rready)
	);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	// Display timing, two stage pipe to line up with color
	always @(negedge CLK) begin
		shown_x <= display_x;
		shown_y <= display_y;
		if (display_x == disp_coord_t'(LINE_LEN - 1)) begin
			display_x <= '0;
			H_tick <= 1'b1;
			display_y <= (display_y == disp_coord_t'(FRAME_H - 1)) ? '0 : display_y + 10'd1;
		end else begin
			display_x <= display_x + 10'd1;
			H_tick <= 1'b0;
		end
	end

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// Memory with 1 to 4 cycles of latency per request
	always @(negedge CLK) begin
		rready = 1'b0;
		if (rvalid) begin
			if (wait_left == 0) begin
				lfsr = lfsr_next(lfsr);
				wait_left = 1 + int'(lfsr[0]);
				lfsr = lfsr_next(lfsr);
				wait_left = wait_left + 2 * int'(lfsr[0]);
			end
			wait_left--;
			if (wait_left == 0) begin
				rready = 1'b1;
				memory_data = {fb_mem[{memory_address, 1'b1}], fb_mem[{memory_address, 1'b0}]};
			end
		end
	end

	always @(posedge CLK) begin
		cycles++;
		if (cycles == TIMEOUT_CYCLES) begin
			$display("Timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
			$display("Some tests failed");
			$finish;
		end
	end

	// Every address bit takes part
	function automatic logic [7:0] fill_byte(input logic [16:0] a);
		logic [7:0] mix;
		mix = a[7:0] * 8'd37;
		return mix ^ a[15:8] ^ {a[16], 7'd0};
	endfunction

	function automatic argb_t expected_color(input int sx, input int sy);
		int          pair;
		int          col;
		int          row;
		logic [16:0] byte_addr;
		pair = sy / 2;
		col = sx / 2;
		row = pair - 1 - int'(win.y1); // Row fetched during the previous pair
		if (win.enable && row >= 0 && pair - 1 < int'(win.y2)
				&& col >= int'(win.x1) && col <= int'(win.x2)) begin
			byte_addr = 17'(2 * int'(win.base) + row * int'(win.stride) + col - int'(win.x1));
			return pal_model[fb_mem[byte_addr]];
		end
		return pal_model[0];
	endfunction

	task automatic cpu_write(input logic pal, input int addr, input int data);
		@(negedge CLK);
		address = REG_ADDR_W'(addr);
		data_in = REG_DATA_W'(data);
		wr_reg = !pal;
		wr_pal = pal;
		@(negedge CLK);
		wr_reg = 1'b0;
		wr_pal = 1'b0;
	endtask

	task automatic write_palette(input logic [15:0] salt);
		argb_t value;
		for (int i = 0; i < 256; i++) begin
			value = 16'(i * 16'h0123) ^ salt; // Distinct per index
			cpu_write(1'b1, i, int'(value));
			pal_model[i] = value;
		end
	endtask

	task automatic wait_line_start(input int y);
		@(negedge CLK);
		while (display_x != 0 || display_y != y) @(negedge CLK);
	endtask

	task automatic configure_window(input fb_cfg_t cfg);
		wait_line_start(FRAME_H - 1); // Blit engine idle on the last line
		cpu_write(1'b0, REG_X1, int'(cfg.x1));
		cpu_write(1'b0, REG_X2, int'(cfg.x2));
		cpu_write(1'b0, REG_Y1, int'(cfg.y1));
		cpu_write(1'b0, REG_Y2, int'(cfg.y2));
		cpu_write(1'b0, REG_STRIDE, int'(cfg.stride));
		cpu_write(1'b0, REG_BASE, int'(cfg.base));
		cpu_write(1'b0, REG_CTRL, int'(cfg.enable));
		win = cfg;
	endtask

	task automatic check_frame(input string name);
		argb_t expected;
		wait_line_start(0); // Frame right after setup is not compared
		wait_line_start(0);
		repeat (FRAME_CYCLES) begin
			@(negedge CLK);
			assert (win.enable || !rvalid) else begin
				errors++;
				$display("Memory request raised while the overlay is off (%s)", name);
			end
			if (shown_x < ACTIVE_W) begin
				checks++;
				expected = expected_color(int'(shown_x), int'(shown_y));
				assert (color === expected) else begin
					errors++;
					$display("Error color = %h, expected %h at x %0d y %0d (%s)",
						color, expected, shown_x, shown_y, name);
				end
			end
		end
	endtask

	// Real window set up, only the enable bit keeps it off
	task automatic disabled_overlay();
		fb_cfg_t cfg;
		cfg = '{enable: 1'b0, x1: 9'd2, x2: 9'd21, y1: 9'd2, y2: 9'd14,
			stride: 9'd40, base: 16'h0100};
		cpu_write(1'b1, 0, 16'hF0A5);
		pal_model[0] = 16'hF0A5;
		configure_window(cfg);
		check_frame("disabled");
	endtask

	// Window over one 256 byte block shows every palette index once
	task automatic palette_sweep();
		fb_cfg_t cfg;
		cfg = '{enable: 1'b1, x1: 9'd4, x2: 9'd19, y1: 9'd2, y2: 9'd18,
			stride: 9'd16, base: 16'h0800};
		write_palette(16'h5A0F);
		configure_window(cfg);
		check_frame("palette");
	endtask

	task automatic doubled_image(input logic [15:0] salt, input string name);
		fb_cfg_t cfg;
		cfg = '{enable: 1'b1, x1: 9'd2, x2: 9'd21, y1: 9'd2, y2: 9'd14,
			stride: 9'd40, base: 16'h0100};
		write_palette(salt);
		configure_window(cfg);
		check_frame(name);
	endtask

	// Odd stride puts every other row start on a high byte
	task automatic odd_stride_window();
		fb_cfg_t cfg;
		cfg = '{enable: 1'b1, x1: 9'd3, x2: 9'd18, y1: 9'd5, y2: 9'd15,
			stride: 9'd37, base: 16'h0233};
		write_palette(16'h3C3C);
		configure_window(cfg);
		check_frame("odd stride");
	endtask

	initial begin
		for (int a = 0; a < 2 ** 17; a++) begin
			fb_mem[a] = fill_byte(17'(a));
		end
		repeat (16) @(negedge CLK);
		RSTb = 1'b1;
		disabled_overlay();
		palette_sweep();
		doubled_image(16'h1E5A, "image");
		odd_stride_window();
		doubled_image(16'h7C81, "image rerun"); // Latencies differ from the first run
		$display("Pixels checked: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule
